// File: rtl/uop_pkg.sv
`default_nettype none

package uop_pkg;

    // architectural destination register
    typedef logic [4:0] areg_t;

    // result value from the execution units
    typedef logic [31:0] data_t;

    // instruction address, kept for exception reporting
    typedef logic [31:0] pc_t;

    // exception cause, zero when the instruction is clean
    typedef logic [3:0] exc_code_t;

    localparam exc_code_t EXC_NONE = exc_code_t'(0);

endpackage

`default_nettype wire

// File: rtl/rob_pkg.sv
`default_nettype none

package rob_pkg;

    // dispatch, writeback and retire all share this width
    localparam int LANES = 2;
    localparam int CNT_W = $clog2(LANES + 1);

    localparam int ROB_DEPTH_DEFAULT = 8;

    typedef logic [LANES-1:0] lane_mask_t;
    typedef logic [CNT_W-1:0] lane_cnt_t;

    // number of set lanes in a mask
    function automatic lane_cnt_t lane_count(lane_mask_t m);
        lane_cnt_t n;
        n = '0;
        for (int i = 0; i < LANES; i++) begin
            n = n + lane_cnt_t'(m[i]);
        end
        return n;
    endfunction

endpackage

`default_nettype wire

// File: rtl/rob_alloc.sv
`timescale 1ns/1ps
`default_nettype none

module rob_alloc #(
    parameter int ROB_DEPTH = rob_pkg::ROB_DEPTH_DEFAULT,
    localparam int IDX_W = $clog2(ROB_DEPTH),
    localparam int PTR_W = IDX_W + 1
) (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  rob_pkg::lane_mask_t                     disp_valid,
    input  logic [PTR_W-1:0]                        head_ptr,
    input  logic                                    exc_flush,
    output logic                                    disp_ready,
    output logic [rob_pkg::LANES-1:0][IDX_W-1:0]    disp_idx,
    output rob_pkg::lane_mask_t                     alloc_en,
    output logic [PTR_W-1:0]                        tail_ptr
);

    logic [PTR_W-1:0]   tail_q;
    logic [PTR_W-1:0]   used_cnt;
    logic [PTR_W-1:0]   free_cnt;
    rob_pkg::lane_cnt_t req_cnt;
    rob_pkg::lane_cnt_t acc_cnt;

    // wrap bit makes full and empty distinct
    assign used_cnt = tail_q - head_ptr;
    assign free_cnt = PTR_W'(ROB_DEPTH) - used_cnt;
    assign req_cnt  = rob_pkg::lane_count(disp_valid);

    // nothing gets in while the buffer is being flushed
    assign disp_ready = !exc_flush && (free_cnt >= PTR_W'(req_cnt));
    assign alloc_en   = disp_ready ? disp_valid : '0;
    assign acc_cnt    = rob_pkg::lane_count(alloc_en);

    always_comb begin
        for (int l = 0; l < rob_pkg::LANES; l++) begin
            disp_idx[l] = tail_q[IDX_W-1:0] + IDX_W'(l);
        end
    end

    assign tail_ptr = tail_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tail_q <= '0;
        end else if (exc_flush) begin
            tail_q <= '0;
        end else begin
            tail_q <= tail_q + PTR_W'(acc_cnt);
        end
    end

endmodule

`default_nettype wire

// File: rtl/rob_table.sv
`timescale 1ns/1ps
`default_nettype none

module rob_table #(
    parameter int ROB_DEPTH = rob_pkg::ROB_DEPTH_DEFAULT,
    localparam int IDX_W = $clog2(ROB_DEPTH),
    localparam int PTR_W = IDX_W + 1
) (
    input  logic                                            clk,
    input  logic                                            rst_n,
    input  rob_pkg::lane_mask_t                             alloc_en,
    input  logic [PTR_W-1:0]                                tail_ptr,
    input  uop_pkg::areg_t [rob_pkg::LANES-1:0]             disp_dst,
    input  uop_pkg::pc_t [rob_pkg::LANES-1:0]               disp_pc,
    input  uop_pkg::exc_code_t [rob_pkg::LANES-1:0]         disp_exc_hint,
    input  rob_pkg::lane_mask_t                             wb_valid,
    input  logic [rob_pkg::LANES-1:0][IDX_W-1:0]            wb_idx,
    input  uop_pkg::data_t [rob_pkg::LANES-1:0]             wb_data,
    input  uop_pkg::exc_code_t [rob_pkg::LANES-1:0]         wb_exc,
    input  logic                                            exc_flush,
    input  logic [PTR_W-1:0]                                head_ptr,
    output rob_pkg::lane_mask_t                             win_alloc,
    output rob_pkg::lane_mask_t                             win_complete,
    output uop_pkg::areg_t [rob_pkg::LANES-1:0]             win_dst,
    output uop_pkg::data_t [rob_pkg::LANES-1:0]             win_data,
    output uop_pkg::pc_t [rob_pkg::LANES-1:0]               win_pc,
    output uop_pkg::exc_code_t [rob_pkg::LANES-1:0]         win_exc
);

    logic [ROB_DEPTH-1:0]   alloc_q;
    logic [ROB_DEPTH-1:0]   complete_q;
    uop_pkg::areg_t         dst_q [ROB_DEPTH];
    uop_pkg::pc_t           pc_q [ROB_DEPTH];
    uop_pkg::data_t         data_q [ROB_DEPTH];
    uop_pkg::exc_code_t     exc_q [ROB_DEPTH];

    logic [rob_pkg::LANES-1:0][IDX_W-1:0] alloc_slot;
    logic [rob_pkg::LANES-1:0][IDX_W-1:0] win_slot;
    logic [PTR_W-1:0]                     occupancy;

    always_comb begin
        for (int l = 0; l < rob_pkg::LANES; l++) begin
            alloc_slot[l] = tail_ptr[IDX_W-1:0] + IDX_W'(l);
            win_slot[l]   = head_ptr[IDX_W-1:0] + IDX_W'(l);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            alloc_q    <= '0;
            complete_q <= '0;
        end else if (exc_flush) begin
            alloc_q <= '0;
        end else begin
            for (int l = 0; l < rob_pkg::LANES; l++) begin
                if (wb_valid[l]) begin
                    complete_q[wb_idx[l]] <= 1'b1;
                end
            end
            // a fresh entry starts out incomplete
            for (int l = 0; l < rob_pkg::LANES; l++) begin
                if (alloc_en[l]) begin
                    alloc_q[alloc_slot[l]]    <= 1'b1;
                    complete_q[alloc_slot[l]] <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int l = 0; l < rob_pkg::LANES; l++) begin
            if (wb_valid[l]) begin
                data_q[wb_idx[l]] <= wb_data[l];
                // keep a decode-time exception unless the unit reports its own
                if (wb_exc[l] != uop_pkg::EXC_NONE) begin
                    exc_q[wb_idx[l]] <= wb_exc[l];
                end
            end
        end
        for (int l = 0; l < rob_pkg::LANES; l++) begin
            if (alloc_en[l]) begin
                dst_q[alloc_slot[l]] <= disp_dst[l];
                pc_q[alloc_slot[l]]  <= disp_pc[l];
                exc_q[alloc_slot[l]] <= disp_exc_hint[l];
            end
        end
    end

    // retired slots keep their bit until reused, the pointer range masks them
    assign occupancy = tail_ptr - head_ptr;

    always_comb begin
        for (int k = 0; k < rob_pkg::LANES; k++) begin
            win_alloc[k]    = alloc_q[win_slot[k]] && (PTR_W'(k) < occupancy);
            win_complete[k] = complete_q[win_slot[k]];
            win_dst[k]      = dst_q[win_slot[k]];
            win_data[k]     = data_q[win_slot[k]];
            win_pc[k]       = pc_q[win_slot[k]];
            win_exc[k]      = exc_q[win_slot[k]];
        end
    end

endmodule

`default_nettype wire

// File: rtl/rob_retire.sv
`timescale 1ns/1ps
`default_nettype none

module rob_retire #(
    parameter int ROB_DEPTH = rob_pkg::ROB_DEPTH_DEFAULT,
    localparam int IDX_W = $clog2(ROB_DEPTH),
    localparam int PTR_W = IDX_W + 1
) (
    input  logic                                            clk,
    input  logic                                            rst_n,
    input  rob_pkg::lane_mask_t                             win_alloc,
    input  rob_pkg::lane_mask_t                             win_complete,
    input  uop_pkg::areg_t [rob_pkg::LANES-1:0]             win_dst,
    input  uop_pkg::data_t [rob_pkg::LANES-1:0]             win_data,
    input  uop_pkg::pc_t [rob_pkg::LANES-1:0]               win_pc,
    input  uop_pkg::exc_code_t [rob_pkg::LANES-1:0]         win_exc,
    output logic [PTR_W-1:0]                                head_ptr,
    output rob_pkg::lane_mask_t                             ret_valid,
    output uop_pkg::areg_t [rob_pkg::LANES-1:0]             ret_dst,
    output uop_pkg::data_t [rob_pkg::LANES-1:0]             ret_data,
    output logic                                            exc_flush,
    output uop_pkg::pc_t                                    exc_pc,
    output uop_pkg::exc_code_t                              exc_code
);

    logic [PTR_W-1:0]       head_q;
    rob_pkg::lane_mask_t    done;
    rob_pkg::lane_mask_t    clean;
    rob_pkg::lane_mask_t    faulted;
    rob_pkg::lane_cnt_t     ret_cnt;
    logic                   exc_sel;

    always_comb begin
        for (int k = 0; k < rob_pkg::LANES; k++) begin
            done[k]    = win_alloc[k] && win_complete[k];
            clean[k]   = done[k] && (win_exc[k] == uop_pkg::EXC_NONE);
            faulted[k] = done[k] && (win_exc[k] != uop_pkg::EXC_NONE);
        end
    end

    // lane 1 only follows a retiring lane 0
    always_comb begin
        ret_valid[0] = clean[0];
        for (int k = 1; k < rob_pkg::LANES; k++) begin
            ret_valid[k] = ret_valid[k-1] && clean[k];
        end
    end

    assign ret_dst  = win_dst;
    assign ret_data = win_data;
    assign ret_cnt  = rob_pkg::lane_count(ret_valid);

    // the faulting entry must be the oldest not yet retired
    assign exc_flush = faulted[0] || (clean[0] && faulted[1]);
    assign exc_sel   = !faulted[0];
    assign exc_pc    = win_pc[exc_sel];
    assign exc_code  = win_exc[exc_sel];

    assign head_ptr = head_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            head_q <= '0;
        end else if (exc_flush) begin
            head_q <= '0;
        end else begin
            head_q <= head_q + PTR_W'(ret_cnt);
        end
    end

endmodule

`default_nettype wire

// File: rtl/rob_top.sv
`timescale 1ns/1ps
`default_nettype none

module rob_top #(
    parameter int ROB_DEPTH = rob_pkg::ROB_DEPTH_DEFAULT,
    localparam int IDX_W = $clog2(ROB_DEPTH),
    localparam int PTR_W = IDX_W + 1
) (
    input  logic                                            clk,
    input  logic                                            rst_n,
    input  rob_pkg::lane_mask_t                             disp_valid,
    input  uop_pkg::areg_t [rob_pkg::LANES-1:0]             disp_dst,
    input  uop_pkg::pc_t [rob_pkg::LANES-1:0]               disp_pc,
    input  uop_pkg::exc_code_t [rob_pkg::LANES-1:0]         disp_exc_hint,
    input  rob_pkg::lane_mask_t                             wb_valid,
    input  logic [rob_pkg::LANES-1:0][IDX_W-1:0]            wb_idx,
    input  uop_pkg::data_t [rob_pkg::LANES-1:0]             wb_data,
    input  uop_pkg::exc_code_t [rob_pkg::LANES-1:0]         wb_exc,
    output logic                                            disp_ready,
    output logic [rob_pkg::LANES-1:0][IDX_W-1:0]            disp_idx,
    output rob_pkg::lane_mask_t                             ret_valid,
    output uop_pkg::areg_t [rob_pkg::LANES-1:0]             ret_dst,
    output uop_pkg::data_t [rob_pkg::LANES-1:0]             ret_data,
    output logic                                            exc_flush,
    output uop_pkg::pc_t                                    exc_pc,
    output uop_pkg::exc_code_t                              exc_code
);

    logic [PTR_W-1:0]                       head_ptr;
    logic [PTR_W-1:0]                       tail_ptr;
    rob_pkg::lane_mask_t                    alloc_en;
    rob_pkg::lane_mask_t                    win_alloc;
    rob_pkg::lane_mask_t                    win_complete;
    uop_pkg::areg_t [rob_pkg::LANES-1:0]    win_dst;
    uop_pkg::data_t [rob_pkg::LANES-1:0]    win_data;
    uop_pkg::pc_t [rob_pkg::LANES-1:0]      win_pc;
    uop_pkg::exc_code_t [rob_pkg::LANES-1:0] win_exc;

    rob_alloc #(.ROB_DEPTH(ROB_DEPTH)) u_alloc (
        .clk        (clk),
        .rst_n      (rst_n),
        .disp_valid (disp_valid),
        .head_ptr   (head_ptr),
        .exc_flush  (exc_flush),
        .disp_ready (disp_ready),
        .disp_idx   (disp_idx),
        .alloc_en   (alloc_en),
        .tail_ptr   (tail_ptr)
    );

    rob_table #(.ROB_DEPTH(ROB_DEPTH)) u_table (
        .clk           (clk),
        .rst_n         (rst_n),
        .alloc_en      (alloc_en),
        .tail_ptr      (tail_ptr),
        .disp_dst      (disp_dst),
        .disp_pc       (disp_pc),
        .disp_exc_hint (disp_exc_hint),
        .wb_valid      (wb_valid),
        .wb_idx        (wb_idx),
        .wb_data       (wb_data),
        .wb_exc        (wb_exc),
        .exc_flush     (exc_flush),
        .head_ptr      (head_ptr),
        .win_alloc     (win_alloc),
        .win_complete  (win_complete),
        .win_dst       (win_dst),
        .win_data      (win_data),
        .win_pc        (win_pc),
        .win_exc       (win_exc)
    );

    rob_retire #(.ROB_DEPTH(ROB_DEPTH)) u_retire (
        .clk          (clk),
        .rst_n        (rst_n),
        .win_alloc    (win_alloc),
        .win_complete (win_complete),
        .win_dst      (win_dst),
        .win_data     (win_data),
        .win_pc       (win_pc),
        .win_exc      (win_exc),
        .head_ptr     (head_ptr),
        .ret_valid    (ret_valid),
        .ret_dst      (ret_dst),
        .ret_data     (ret_data),
        .exc_flush    (exc_flush),
        .exc_pc       (exc_pc),
        .exc_code     (exc_code)
    );

endmodule

`default_nettype wire

// File: testbench/rob_properties.sv
`timescale 1ns/1ps
`default_nettype none

module rob_properties #(
    parameter int ROB_DEPTH = rob_pkg::ROB_DEPTH_DEFAULT,
    localparam int PTR_W = $clog2(ROB_DEPTH) + 1
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  rob_pkg::lane_mask_t     disp_valid,
    input  logic                    disp_ready,
    input  rob_pkg::lane_mask_t     ret_valid,
    input  logic                    exc_flush,
    input  logic [PTR_W-1:0]        head_ptr,
    input  logic [PTR_W-1:0]        tail_ptr
);

    logic [PTR_W-1:0] occupancy;

    assign occupancy = tail_ptr - head_ptr;

    lane1_needs_lane0: assert property (@(posedge clk) disable iff (!rst_n)
        ret_valid[1] |-> ret_valid[0])
        else $error("lane 1 retired while lane 0 did not");

    // both pointers back at zero, nothing blocks dispatch
    flush_empties_buffer: assert property (@(posedge clk) disable iff (!rst_n)
        exc_flush |=> (occupancy == '0) && disp_ready)
        else $error("buffer not empty and ready in the cycle after a flush");

    ready_respects_space: assert property (@(posedge clk) disable iff (!rst_n)
        (int'(occupancy) + $countones(disp_valid) > ROB_DEPTH) |-> !disp_ready)
        else $error("disp_ready high without room for the requested lanes");

endmodule

bind rob_top rob_properties #(.ROB_DEPTH(ROB_DEPTH)) u_props (
    .clk        (clk),
    .rst_n      (rst_n),
    .disp_valid (disp_valid),
    .disp_ready (disp_ready),
    .ret_valid  (ret_valid),
    .exc_flush  (exc_flush),
    .head_ptr   (head_ptr),
    .tail_ptr   (tail_ptr)
);

`default_nettype wire

// File: testbench/tb_rob.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rob;

    localparam int DEPTH = rob_pkg::ROB_DEPTH_DEFAULT;
    localparam int IDX_W = $clog2(DEPTH);

    logic                                           clk;
    logic                                           rst_n;
    rob_pkg::lane_mask_t                            disp_valid;
    uop_pkg::areg_t [rob_pkg::LANES-1:0]            disp_dst;
    uop_pkg::pc_t [rob_pkg::LANES-1:0]              disp_pc;
    uop_pkg::exc_code_t [rob_pkg::LANES-1:0]        disp_exc_hint;
    rob_pkg::lane_mask_t                            wb_valid;
    logic [rob_pkg::LANES-1:0][IDX_W-1:0]           wb_idx;
    uop_pkg::data_t [rob_pkg::LANES-1:0]            wb_data;
    uop_pkg::exc_code_t [rob_pkg::LANES-1:0]        wb_exc;
    logic                                           disp_ready;
    logic [rob_pkg::LANES-1:0][IDX_W-1:0]           disp_idx;
    rob_pkg::lane_mask_t                            ret_valid;
    uop_pkg::areg_t [rob_pkg::LANES-1:0]            ret_dst;
    uop_pkg::data_t [rob_pkg::LANES-1:0]            ret_data;
    logic                                           exc_flush;
    uop_pkg::pc_t                                   exc_pc;
    uop_pkg::exc_code_t                             exc_code;

    // reference model per buffer slot
    uop_pkg::areg_t     m_dst [DEPTH];
    uop_pkg::pc_t       m_pc [DEPTH];
    uop_pkg::data_t     m_data [DEPTH];
    uop_pkg::exc_code_t m_exc [DEPTH];
    bit                 m_done [DEPTH];
    int                 order_q [$];
    int                 m_tail;
    logic [31:0]        lfsr;
    uop_pkg::pc_t       pc_next;

    // stimulus table columns
    string              t_name [$];
    logic [1:0]         t_disp [$];
    logic [9:0]         t_dst [$];
    uop_pkg::pc_t       t_pc [$];
    logic [1:0]         t_wb [$];
    logic [7:0]         t_off [$];
    logic [7:0]         t_exc [$];
    bit                 t_settle [$];

    rob_top #(.ROB_DEPTH(DEPTH)) u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    task automatic compare_values(input string name, input logic [31:0] expected,
                                  input logic [31:0] actual);
        if (actual !== expected) begin
            fail_now($sformatf("Mismatch %s: expected %h, actual %h", name, expected, actual));
        end
    endtask

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
    endfunction

    // one step per bit handed out
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
        return v;
    endfunction

    // oldest incomplete entry as an offset back from youngest
    // returns -1 when every entry is complete
    function automatic int oldest_undone();
        for (int p = 0; p < order_q.size(); p++) begin
            if (!m_done[order_q[p]]) begin
                return order_q.size() - 1 - p;
            end
        end
        return -1;
    endfunction

    task automatic add_row(input string name, input logic [1:0] disp, input uop_pkg::areg_t d0,
                           input uop_pkg::areg_t d1, input uop_pkg::pc_t pc, input logic [1:0] wb,
                           input int o0, input uop_pkg::exc_code_t e0, input int o1,
                           input uop_pkg::exc_code_t e1, input bit settle);
        t_name.push_back(name);
        t_disp.push_back(disp);
        t_dst.push_back({d1, d0});
        t_pc.push_back(pc);
        t_wb.push_back(wb);
        t_off.push_back({4'(o1), 4'(o0)});
        t_exc.push_back({e1, e0});
        t_settle.push_back(settle);
    endtask

    task automatic apply_cycle(input string name, input logic [1:0] dmask, input logic [9:0] dst,
                               input uop_pkg::pc_t pc, input logic [7:0] hint,
                               input logic [1:0] wmask, input logic [7:0] off,
                               input logic [7:0] exc, output bit accepted);
        int  nret;
        int  pos;
        int  idx;
        bit  flush;
        bit  ready;
        @(negedge clk);
        disp_valid = dmask;
        for (int l = 0; l < rob_pkg::LANES; l++) begin
            disp_dst[l]      = dst[l*5 +: 5];
            disp_pc[l]       = pc + 32'(4 * l);
            disp_exc_hint[l] = hint[l*4 +: 4];
            wb_valid[l]      = wmask[l];
            wb_idx[l]        = '0;
            wb_data[l]       = '0;
            wb_exc[l]        = exc[l*4 +: 4];
            if (wmask[l]) begin
                pos = order_q.size() - 1 - int'(off[l*4 +: 4]);
                if (pos < 0) begin
                    fail_now($sformatf("%s: writeback lane %0d targets no entry", name, l));
                end else begin
                    wb_idx[l]  = IDX_W'(order_q[pos]);
                    wb_data[l] = rand_bits(32);
                end
            end
        end
        #2;
        nret = 0;
        while (nret < 2 && nret < order_q.size() && m_done[order_q[nret]] &&
               m_exc[order_q[nret]] == uop_pkg::EXC_NONE) begin
            nret++;
        end
        flush = (nret < 2) && (nret < order_q.size()) && m_done[order_q[nret]];
        ready = !flush && ((DEPTH - order_q.size()) >= $countones(dmask));
        compare_values({name, " ret_valid"}, 32'((1 << nret) - 1), 32'(ret_valid));
        for (int l = 0; l < nret; l++) begin
            compare_values($sformatf("%s ret_dst%0d", name, l), 32'(m_dst[order_q[l]]),
                           32'(ret_dst[l]));
            compare_values($sformatf("%s ret_data%0d", name, l), m_data[order_q[l]], ret_data[l]);
        end
        compare_values({name, " exc_flush"}, 32'(flush), 32'(exc_flush));
        if (flush) begin
            compare_values({name, " exc_pc"}, m_pc[order_q[nret]], exc_pc);
            compare_values({name, " exc_code"}, 32'(m_exc[order_q[nret]]), 32'(exc_code));
        end
        compare_values({name, " disp_ready"}, 32'(ready), 32'(disp_ready));
        for (int l = 0; l < rob_pkg::LANES; l++) begin
            compare_values($sformatf("%s disp_idx%0d", name, l), 32'((m_tail + l) % DEPTH),
                           32'(disp_idx[l]));
        end
        accepted = (dmask == 2'b00) || ready;
        if (flush) begin
            order_q.delete();
            m_tail = 0;
        end else begin
            for (int l = 0; l < rob_pkg::LANES; l++) begin
                if (wmask[l]) begin
                    idx = int'(wb_idx[l]);
                    m_done[idx] = 1'b1;
                    m_data[idx] = wb_data[l];
                    if (wb_exc[l] != uop_pkg::EXC_NONE) begin
                        m_exc[idx] = wb_exc[l];
                    end
                end
            end
            repeat (nret) void'(order_q.pop_front());
            for (int l = 0; l < rob_pkg::LANES; l++) begin
                if (ready && dmask[l]) begin
                    order_q.push_back(m_tail);
                    m_dst[m_tail]  = disp_dst[l];
                    m_pc[m_tail]   = disp_pc[l];
                    m_exc[m_tail]  = disp_exc_hint[l];
                    m_done[m_tail] = 1'b0;
                    m_tail = (m_tail + 1) % DEPTH;
                end
            end
        end
    endtask

    task automatic cycle_completing_oldest(input string name, input logic [1:0] dmask,
                                           input logic [9:0] dst, input uop_pkg::pc_t pc,
                                           input logic [7:0] hint, output bit accepted);
        int o;
        o = oldest_undone();
        apply_cycle(name, dmask, dst, pc, hint, {1'b0, o >= 0}, 8'(o < 0 ? 0 : o), 8'h00,
                    accepted);
    endtask

    // sender keeps its dispatch up until it is taken
    task automatic dispatch_held(input string name, input logic [1:0] dmask, input logic [9:0] dst,
                                 input uop_pkg::pc_t pc, input logic [7:0] hint,
                                 input logic [1:0] wmask, input logic [7:0] off,
                                 input logic [7:0] exc);
        bit acc;
        int waited;
        apply_cycle(name, dmask, dst, pc, hint, wmask, off, exc, acc);
        waited = 0;
        while (!acc) begin
            if (waited == 20) begin
                fail_now($sformatf("%s: disp_ready stayed low for 20 cycles", name));
            end else begin
                cycle_completing_oldest(name, dmask, dst, pc, hint, acc);
                waited++;
            end
        end
    endtask

    task automatic drain(input string name);
        bit acc;
        int waited;
        waited = 0;
        while (order_q.size() > 0) begin
            if (waited == 4 * DEPTH) begin
                fail_now($sformatf("%s: buffer still not empty after %0d cycles", name, waited));
            end else begin
                cycle_completing_oldest(name, 2'b00, 10'h0, 32'h0, 8'h00, acc);
                waited++;
            end
        end
    endtask

    initial begin
        logic [1:0]  dmask;
        logic [9:0]  dst;
        logic [7:0]  hint;
        logic [1:0]  wmask;
        logic [7:0]  off;
        logic [7:0]  exc;
        int          undone [$];
        int          k;
        lfsr    = 32'h5d624142;
        m_tail  = 0;
        pc_next = 32'h0000_1000;
        rst_n         = 1'b0;
        disp_valid    = '0;
        disp_dst      = '0;
        disp_pc       = '0;
        disp_exc_hint = '0;
        wb_valid      = '0;
        wb_idx        = '0;
        wb_data       = '0;
        wb_exc        = '0;

        // name, disp mask, dst0, dst1, pc, wb mask, off0, exc0, off1, exc1, settle
        add_row("b2_disp_ab", 2'b11, 5'd1, 5'd2, 32'h100, 2'b00, 0, 4'h0, 0, 4'h0, 1'b0);
        add_row("b2_disp_c", 2'b01, 5'd3, 5'd0, 32'h108, 2'b00, 0, 4'h0, 0, 4'h0, 1'b0);
        add_row("b2_wb_c_b", 2'b00, 5'd0, 5'd0, 32'h0, 2'b11, 0, 4'h0, 1, 4'h0, 1'b0);
        add_row("b2_wb_a", 2'b00, 5'd0, 5'd0, 32'h0, 2'b01, 2, 4'h0, 0, 4'h0, 1'b0);
        add_row("b2_ret_ab", 2'b00, 5'd0, 5'd0, 32'h0, 2'b00, 0, 4'h0, 0, 4'h0, 1'b0);
        add_row("b2_ret_c", 2'b00, 5'd0, 5'd0, 32'h0, 2'b00, 0, 4'h0, 0, 4'h0, 1'b1);
        for (int i = 0; i < DEPTH / 2; i++) begin
            add_row("b3_fill", 2'b11, 5'(4 + 2 * i), 5'(5 + 2 * i), 32'(32'h200 + 8 * i),
                    2'b00, 0, 4'h0, 0, 4'h0, 1'b0);
        end
        add_row("b3_full", 2'b01, 5'd20, 5'd0, 32'h240, 2'b01, DEPTH - 1, 4'h0, 0, 4'h0, 1'b1);
        add_row("b4_disp_ab", 2'b11, 5'd13, 5'd14, 32'h300, 2'b00, 0, 4'h0, 0, 4'h0, 1'b0);
        add_row("b4_disp_cd", 2'b11, 5'd15, 5'd16, 32'h308, 2'b00, 0, 4'h0, 0, 4'h0, 1'b0);
        add_row("b4_wb_exc", 2'b00, 5'd0, 5'd0, 32'h0, 2'b11, 2, 4'h5, 3, 4'h0, 1'b0);
        add_row("b4_flush", 2'b00, 5'd0, 5'd0, 32'h0, 2'b01, 0, 4'h0, 0, 4'h0, 1'b0);
        for (int i = 0; i < DEPTH / 2; i++) begin
            add_row("b4_refill", 2'b11, 5'(21 + i), 5'(25 + i), 32'(32'h400 + 8 * i),
                    2'b00, 0, 4'h0, 0, 4'h0, i == DEPTH / 2 - 1);
        end

        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        #2;
        compare_values("reset ret_valid", 32'h0, 32'(ret_valid));
        compare_values("reset exc_flush", 32'h0, 32'(exc_flush));
        compare_values("reset disp_ready", 32'h1, 32'(disp_ready));

        for (int i = 0; i < t_name.size(); i++) begin
            dispatch_held(t_name[i], t_disp[i], t_dst[i], t_pc[i], 8'h00, t_wb[i], t_off[i],
                          t_exc[i]);
            if (t_settle[i]) begin
                drain(t_name[i]);
            end
        end

        // random completion order across many pointer wraps
        for (int c = 0; c < 300; c++) begin
            dmask = 2'(rand_bits(2));
            if (dmask == 2'b10) begin
                dmask = 2'b11;
            end
            dst = 10'(rand_bits(10));
            // decode-time exception on a few entries
            hint = 8'h00;
            for (int l = 0; l < rob_pkg::LANES; l++) begin
                if (rand_bits(6) == 0) begin
                    hint[l*4 +: 4] = 4'(rand_bits(3)) + 4'd1;
                end
            end
            undone.delete();
            for (int p = 0; p < order_q.size(); p++) begin
                if (!m_done[order_q[p]]) begin
                    undone.push_back(p);
                end
            end
            wmask = 2'b00;
            off   = 8'h00;
            exc   = 8'h00;
            for (int l = 0; l < rob_pkg::LANES; l++) begin
                if (undone.size() > 0 && rand_bits(2) != 0) begin
                    k = int'(rand_bits(3)) % undone.size();
                    wmask[l] = 1'b1;
                    off[l*4 +: 4] = 4'(order_q.size() - 1 - undone[k]);
                    if (rand_bits(5) == 0) begin
                        exc[l*4 +: 4] = 4'(rand_bits(3)) + 4'd1;
                    end
                    undone.delete(k);
                end
            end
            dispatch_held("random", dmask, dst, pc_next, hint, wmask, off, exc);
            pc_next = pc_next + 32'(4 * $countones(dmask));
        end
        drain("final_drain");

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
rtl/uop_pkg.sv
rtl/rob_pkg.sv
rtl/rob_alloc.sv
rtl/rob_table.sv
rtl/rob_retire.sv
rtl/rob_top.sv
testbench/rob_properties.sv
testbench/tb_rob.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_rob
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := TESTBENCH PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
